// ==== files.f ====
rio_pkg.sv
rio_cmd_if.sv
frame_receiver.sv
frame_transmitter.sv
prn_scrambler.sv
adc_spi_master.sv
sync_pulse_gen.sv
remote_io_target.sv
rio_assertions.sv
rio_checker.sv
tb_remote_io.sv

// ==== Bender.yml ====
package:
  name: remote_io_target

sources:
  - rio_pkg.sv
  - rio_cmd_if.sv
  - frame_receiver.sv
  - frame_transmitter.sv
  - prn_scrambler.sv
  - adc_spi_master.sv
  - sync_pulse_gen.sv
  - remote_io_target.sv
  - target: test
    files:
      - rio_assertions.sv
      - rio_checker.sv
      - tb_remote_io.sv

// ==== tb_remote_io.sv ====
// Testbench top for the remote IO target, drives host frames and converter models from a table
module tb_remote_io;

   timeunit 1ns;
   timeprecision 1ps;

   typedef struct
   {
      logic [3:0]  addr;
      logic [15:0] data;
      int          mode;     // 1 puts a wrong training nibble in group 2
      logic [7:0]  exp_rb;
      string       name;
   } entry_t;

   logic       clock = 1'b0;
   logic       rst;
   logic [1:0] rx_pair;
   logic [7:0] adc_bus;
   logic [1:0] spi_miso;
   logic [1:0] tx_pair;
   logic [1:0] spi_sck;
   logic [1:0] spi_mosi;
   logic [1:0] spi_cs_n;
   logic       sync;
   entry_t     tests [10];
   logic [7:0] reply [2] = '{8'hA5, 8'h3C};   // Bytes each converter model returns
   int         spi_cnt [2] = '{0, 0};
   logic [1:0] sck_d = '0;
   int         timeouts = 0;
   int         asrt_fails = 0;   // Failures of the bound timing assertions

   remote_io_target uut
   (
      .clock    (clock),
      .rst      (rst),
      .rx_pair  (rx_pair),
      .adc_bus  (adc_bus),
      .spi_miso (spi_miso),
      .tx_pair  (tx_pair),
      .spi_sck  (spi_sck),
      .spi_mosi (spi_mosi),
      .spi_cs_n (spi_cs_n),
      .sync     (sync)
   );

   rio_checker chk
   (
      .clock    (clock),
      .rst      (rst),
      .rx_pair  (rx_pair),
      .adc_bus  (adc_bus),
      .tx_pair  (uut.tx_pair),
      .spi_sck  (uut.spi_sck),
      .spi_mosi (uut.spi_mosi),
      .spi_cs_n (uut.spi_cs_n),
      .sync     (uut.sync)
   );

   bind adc_spi_master rio_assertions spi_asrt
   (
      .clock (clock), .rst (rst), .strobe (start), .cs_n (cs_n), .sck (sck), .wvalid (1'b0)
   );

   bind frame_receiver rio_assertions rx_asrt
   (
      .clock (clock), .rst (rst), .strobe (1'b0), .cs_n (1'b1), .sck (1'b0),
      .wvalid (cmd.wvalid)
   );

   always #10 clock = ~clock;

   // Converter models answer with their reply byte, one bit per rising sck
   always @(negedge clock)
   begin
      for (int ch = 0; ch < 2; ch++)
      begin
         if (spi_cs_n[ch])
            spi_cnt[ch] = 0;
         else if (spi_sck[ch] && !sck_d[ch])
         begin
            spi_cnt[ch]++;
            spi_miso[ch] = reply[ch][7 - ((spi_cnt[ch] - 1) % 8)];
         end
      end
      sck_d = spi_sck;
   end

   // Training nibbles in groups 0 to 2, random bytes elsewhere
   function automatic logic [7:0] adc_value(input int g, input int mode);
      logic [7:0] r;
      r = 8'($urandom);
      if ((g == 0) || (g >= 32))
         r[3:0] = rio_pkg::train_pattern_0;
      else if (g == 1)
         r[3:0] = rio_pkg::train_pattern_1;
      else if (g == 2)
         r[3:0] = (mode == 1) ? ~rio_pkg::train_pattern_2 : rio_pkg::train_pattern_2;
      return r;
   endfunction

   task automatic send_frame(input logic [3:0] addr, input logic [15:0] data, input int mode);
      logic [19:0] w;
      w = {addr, data};
      for (int c = 0; c < rio_pkg::frame_len; c++)
      begin
         @(negedge clock);
         if (c == 0)
            rx_pair = 2'b00;                  // Start pair
         else if (c <= 10)
            rx_pair = w[19-2*(c-1) -: 2];
         else
            rx_pair = 2'b11;
         adc_bus = adc_value((c + 1) >> 2, mode);   // Sampled one clock before its group loads
      end
   endtask

   task automatic wait_readback();
      int n;
      n = 0;
      while (!chk.rb_seen && (n < 256))
      begin
         @(negedge clock);
         n++;
      end
      if (!chk.rb_seen)
      begin
         $display("Timed out waiting for the readback byte of the returned frame");
         timeouts++;
      end
   endtask

   initial
   begin
      rx_pair  = 2'b11;
      adc_bus  = '0;
      spi_miso = '0;
      rst      = 1'b1;
      void'($urandom(96962));
      tests[0] = '{4'd4, 16'h1234, 0, 8'h34, "prn_restart"};
      tests[1] = '{4'd0, 16'hBEEF, 0, 8'hEF, "echo_write"};
      tests[2] = '{4'd2, 16'hC3A1, 0, 8'hA5, "spi0_write"};
      tests[3] = '{4'd3, 16'h5A0F, 0, 8'h3C, "spi1_write"};
      tests[4] = '{4'd1, 16'h0028, 0, 8'h28, "sync_arm"};
      tests[5] = '{4'd1, 16'h0028, 0, 8'h28, "sync_repeat"};
      tests[6] = '{4'd6, 16'h0000, 0, 8'h00, "status_good"};
      tests[7] = '{4'd6, 16'h0000, 1, 8'h01, "status_bad"};
      tests[8] = '{4'd6, 16'h0000, 0, 8'h00, "status_recover"};
      tests[9] = '{4'd15, 16'h00C6, 0, 8'hC6, "echo_high_addr"};
      repeat (5) @(negedge clock);
      rst = 1'b0;
      repeat (2) @(negedge clock);
      foreach (tests[i])
      begin
         send_frame(tests[i].addr, tests[i].data, tests[i].mode);
         wait_readback();
         chk.end_test(tests[i].name, tests[i].addr, tests[i].data, tests[i].exp_rb);
      end
      asrt_fails = uut.u_spi0.spi_asrt.fails + uut.u_spi1.spi_asrt.fails
                   + uut.u_rx.rx_asrt.fails;
      $display("Tests passed %0d, failed %0d, timeouts %0d, assertion failures %0d",
               chk.n_pass, chk.n_fail, timeouts, asrt_fails);
      if ((chk.n_fail == 0) && (timeouts == 0) && (asrt_fails == 0))
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

   initial
   begin
      repeat (4000) @(posedge clock);
      $display("Simulation watchdog expired before the test table finished");
      $display("Result: FAILED");
      $finish;
   end

endmodule

// ==== rio_checker.sv ====
// Link monitor for the testbench, models the return frame, scrambler and sync, counts results
module rio_checker
(
   input logic       clock,
   input logic       rst,
   input logic [1:0] rx_pair,
   input logic [7:0] adc_bus,
   input logic [1:0] tx_pair,
   input logic [1:0] spi_sck,
   input logic [1:0] spi_mosi,
   input logic [1:0] spi_cs_n,
   input logic       sync
);

   timeunit 1ns;
   timeprecision 1ps;

   localparam int lw = rio_pkg::lfsr_width;

   int              n_pass = 0;
   int              n_fail = 0;
   int              cur_err = 0;
   logic [6:0]      slot;           // Slot as seen by the host side
   logic [19:0]     word;
   logic [3:0]      c_addr = '0;
   logic [15:0]     c_data = '0;
   logic [lw-1:0]   lfsr;
   logic [1:0]      div;
   logic [7:0]      adc_d;          // Converter bus one clock late
   logic [7:0]      exp_grp [32];
   logic            chk_grp [32] = '{default: 1'b0};
   logic            armed = 1'b0;
   logic [6:0]      tgt;
   logic            exp_sync = 1'b1;
   logic [7:0]      got_rb = '0;
   logic            rb_seen = 1'b0;
   logic            in_rst = 1'b0;  // A reset edge has already passed
   logic [15:0]     sword [2];
   int              sbits [2] = '{0, 0};
   int              xfers [2] = '{0, 0};
   logic [15:0]     last_word [2];
   int              last_bits [2] = '{0, 0};
   logic [1:0]      sck_d = '0;
   logic [1:0]      cs_d = '1;

   // Eight register steps, new bit from bits 22 and 21 enters at the bottom
   function automatic logic [lw-1:0] lfsr_advance(input logic [lw-1:0] s);
      logic [lw-1:0] r;
      r = s;
      for (int i = 0; i < 8; i++)
      begin
         r = {r[lw-2:0], r[lw-1] ^ r[lw-2]};
      end
      return r;
   endfunction

   task automatic value_error(input string sig, input logic [15:0] got, input logic [15:0] exp);
      $display("ERROR %s: got %h expected %h", sig, got, exp);
      cur_err++;
   endtask

   always @(posedge clock)
   begin : model
      int t;
      int g;
      int k;
      if (rst)
      begin
         // The idle link sends ones while the target is held in reset
         if (in_rst && (tx_pair !== 2'b11))
            value_error("tx_pair in reset", tx_pair, 2'b11);
         in_rst   = 1'b1;
         slot     = '0;
         lfsr     = rio_pkg::lfsr_seed;
         div      = '0;
         armed    = 1'b0;
         exp_sync = 1'b1;
      end
      else
      begin
         in_rst = 1'b0;
         t = slot;
         if (sync !== exp_sync)
            value_error($sformatf("sync at slot %0d", t), sync, exp_sync);
         if (t >= 2)
         begin
            g = (t - 2) >> 2;
            k = (t - 2) & 3;
            if (chk_grp[g] && (tx_pair !== exp_grp[g][7-2*k -: 2]))
               value_error($sformatf("tx_pair group %0d", g), tx_pair, exp_grp[g][7-2*k -: 2]);
         end
         if (t >= 114 && t <= 117)
            got_rb = {got_rb[5:0], tx_pair};   // Readback group bits, MSB first
         if (t == 117)
            rb_seen = 1'b1;

         exp_sync = !(armed && (slot == tgt));
         if (t % rio_pkg::byte_slots == 0)
         begin
            g = t / rio_pkg::byte_slots;
            chk_grp[g] = (g >= rio_pkg::first_data_group) && (g <= rio_pkg::marker_group);
            exp_grp[g] = (g == rio_pkg::marker_group) ? 8'hFF : (adc_d ^ lfsr[7:0]);
         end

         if (t >= 1 && t <= 10)
            word = {word[17:0], rx_pair};
         if (t == rio_pkg::capture_slot)
            {c_addr, c_data} = word;
         if (t == rio_pkg::capture_slot + 1)
         begin
            armed = (c_addr == rio_pkg::addr_sync);
            tgt   = c_data[6:0];
         end
         if ((t == rio_pkg::capture_slot + 1) && (c_addr == rio_pkg::addr_prn_reset))
         begin
            lfsr = rio_pkg::lfsr_seed;
            div  = '0;
         end
         else
         begin
            if (div == '0)
               lfsr = lfsr_advance(lfsr);
            div = div + 1'b1;
         end

         if (((slot == 0) || (slot > rio_pkg::idle_check_slot)) && !rx_pair[1])
            slot = 7'd1;
         else if (slot == 7'(rio_pkg::frame_len - 1))
            slot = '0;
         else if (slot != 0)
            slot = slot + 1'b1;
      end
      adc_d = adc_bus;
   end

   // Converter side, mosi taken once per rising sck
   always @(negedge clock)
   begin
      for (int ch = 0; ch < 2; ch++)
      begin
         if (!rst && !spi_cs_n[ch] && cs_d[ch])
         begin
            sword[ch] = '0;
            sbits[ch] = 0;
         end
         if (!rst && !spi_cs_n[ch] && spi_sck[ch] && !sck_d[ch])
         begin
            sword[ch] = {sword[ch][14:0], spi_mosi[ch]};
            sbits[ch]++;
         end
         if (!rst && spi_cs_n[ch] && !cs_d[ch])
         begin
            xfers[ch]++;
            last_word[ch] = sword[ch];
            last_bits[ch] = sbits[ch];
         end
         sck_d[ch] = spi_sck[ch];
         cs_d[ch]  = spi_cs_n[ch];
      end
   end

   task automatic end_test(input string name, input logic [3:0] addr, input logic [15:0] data,
                           input logic [7:0] exp_rb);
      int want;
      if (got_rb !== exp_rb)
         value_error("tx_pair readback", got_rb, exp_rb);
      for (int ch = 0; ch < 2; ch++)
      begin
         want = (int'(addr) == int'(rio_pkg::addr_spi0) + ch);
         if (want && ((xfers[ch] != 1) || (last_bits[ch] != rio_pkg::spi_len)))
         begin
            $display("Converter %0d saw %0d transfers with %0d bits instead of one 16-bit write",
                     ch, xfers[ch], last_bits[ch]);
            cur_err++;
         end
         else if (want && (last_word[ch] !== data))
            value_error($sformatf("spi_mosi[%0d]", ch), last_word[ch], data);
         else if (!want && (xfers[ch] != 0))
         begin
            $display("Converter %0d was not idle during a frame addressed elsewhere", ch);
            cur_err++;
         end
         xfers[ch] = 0;
      end
      if (cur_err == 0)
      begin
         $display("PASS %s", name);
         n_pass++;
      end
      else
      begin
         $display("FAIL %s with %0d errors", name, cur_err);
         n_fail++;
      end
      cur_err = 0;
      rb_seen = 1'b0;
   endtask

endmodule

// ==== rio_assertions.sv ====
// Bound SPI and frame timing assertions, attached to the SPI masters and the frame receiver
module rio_assertions
(
   input logic clock,
   input logic rst,
   input logic strobe,
   input logic cs_n,
   input logic sck,
   input logic wvalid
);

   timeunit 1ns;
   timeprecision 1ps;

   int fails = 0;   // Count of failed assertions in this instance

   // Chip select covers the whole 16-bit transfer and nothing more
   property cs_window;
      @(posedge clock) disable iff (rst)
         strobe |=> (!cs_n) [*64] ##1 cs_n;
   endproperty

   property sck_idle;
      @(posedge clock) disable iff (rst)
         cs_n |-> !sck;
   endproperty

   // The earliest restart is at slot 121, so strobes are at least 121 cycles apart
   property one_cmd_per_frame;
      @(posedge clock) disable iff (rst)
         wvalid |=> (!wvalid) [*120];
   endproperty

   cs_window_chk : assert property (cs_window)
      else
      begin
         $error("SPI chip select was not low for exactly 64 cycles after the strobe");
         fails++;
      end

   sck_idle_chk : assert property (sck_idle)
      else
      begin
         $error("SPI clock was high while chip select was high");
         fails++;
      end

   cmd_rate_chk : assert property (one_cmd_per_frame)
      else
      begin
         $error("Command strobe fired twice within one frame");
         fails++;
      end

endmodule

// ==== remote_io_target.sv ====
// Top level of the remote IO target, connects the link, converter SPI and sync blocks
module remote_io_target
(
   input  logic       clock,
   input  logic       rst,
   input  logic [1:0] rx_pair,
   input  logic [7:0] adc_bus,
   input  logic [1:0] spi_miso,
   output logic [1:0] tx_pair,
   output logic [1:0] spi_sck,
   output logic [1:0] spi_mosi,
   output logic [1:0] spi_cs_n,
   output logic       sync
);

   rio_cmd_if cmd ();

   logic [7:0] prn_word;
   logic [7:0] spi0_rdata;
   logic [7:0] spi1_rdata;

   frame_receiver u_rx
   (
      .clock   (clock),
      .rst     (rst),
      .rx_pair (rx_pair),
      .cmd     (cmd.source)
   );

   frame_transmitter u_tx
   (
      .clock      (clock),
      .rst        (rst),
      .cmd        (cmd.sink),
      .adc_bus    (adc_bus),
      .prn_word   (prn_word),
      .spi0_rdata (spi0_rdata),
      .spi1_rdata (spi1_rdata),
      .tx_pair    (tx_pair)
   );

   prn_scrambler u_prn
   (
      .clock    (clock),
      .rst      (rst),
      .cmd      (cmd.sink),
      .prn_word (prn_word)
   );

   adc_spi_master #(.port_addr(rio_pkg::addr_spi0)) u_spi0
   (
      .clock (clock),
      .rst   (rst),
      .cmd   (cmd.sink),
      .sck   (spi_sck[0]),
      .mosi  (spi_mosi[0]),
      .cs_n  (spi_cs_n[0]),
      .miso  (spi_miso[0]),
      .rdata (spi0_rdata)
   );

   adc_spi_master #(.port_addr(rio_pkg::addr_spi1)) u_spi1
   (
      .clock (clock),
      .rst   (rst),
      .cmd   (cmd.sink),
      .sck   (spi_sck[1]),
      .mosi  (spi_mosi[1]),
      .cs_n  (spi_cs_n[1]),
      .miso  (spi_miso[1]),
      .rdata (spi1_rdata)
   );

   sync_pulse_gen u_sync
   (
      .clock (clock),
      .rst   (rst),
      .cmd   (cmd.sink),
      .sync  (sync)
   );

endmodule

// ==== sync_pulse_gen.sv ====
// Converter sync output, pulses low once per frame at the slot armed by a host command
module sync_pulse_gen
(
   input  logic    clock,
   input  logic    rst,
   rio_cmd_if.sink cmd,
   output logic    sync
);

   logic                            armed;        // Last command was a sync command
   logic [rio_pkg::slot_width-1:0]  target_slot;

   always_ff @(posedge clock)
   begin
      if (cmd.wvalid && (cmd.addr == rio_pkg::addr_sync))
      begin
         target_slot <= cmd.wdata[rio_pkg::slot_width-1:0];
      end
   end

   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         armed <= 1'b0;
         sync  <= 1'b1;
      end
      else
      begin
         if (cmd.wvalid)
         begin
            armed <= (cmd.addr == rio_pkg::addr_sync);   // Any other command disarms
         end
         sync <= !(armed && (cmd.slot == target_slot));
      end
   end

endmodule

// ==== adc_spi_master.sv ====
// SPI master toward one converter, sends a 16-bit write and keeps the last byte seen on miso
module adc_spi_master
#(
   parameter logic [rio_pkg::addr_width-1:0] port_addr = rio_pkg::addr_spi0
)
(
   input  logic       clock,
   input  logic       rst,
   rio_cmd_if.sink    cmd,
   output logic       sck,
   output logic       mosi,
   output logic       cs_n,
   input  logic       miso,
   output logic [7:0] rdata
);

   logic [5:0]                 phase;   // Four phases per bit, zero when idle
   logic [rio_pkg::spi_len-1:0] sro;    // Outgoing word
   logic                       start;

   assign start = cmd.wvalid && (cmd.addr == port_addr);

   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         phase <= '0;
         cs_n  <= 1'b1;
         sck   <= 1'b0;
         sro   <= '0;
         mosi  <= 1'b0;
      end
      else
      begin
         if (start)
         begin
            phase <= 6'd1;
         end
         else if (phase != '0)
         begin
            phase <= phase + 1'b1;   // Wraps to zero after the last bit
         end

         if (start)
         begin
            cs_n <= 1'b0;
         end
         else if (phase == '0)
         begin
            cs_n <= 1'b1;
         end

         sck <= (phase[1:0] == 2'd1) || (phase[1:0] == 2'd2);

         if (start)
         begin
            sro <= cmd.wdata;
         end
         else if (phase[1:0] == 2'd2)
         begin
            sro <= {sro[rio_pkg::spi_len-2:0], 1'b0};
         end

         mosi <= sro[rio_pkg::spi_len-1];
      end
   end

   // Response byte, sampled late in each bit while sck is low
   always_ff @(posedge clock)
   begin
      if (phase[1:0] == 2'd3)
      begin
         rdata <= {rdata[6:0], miso};
      end
   end

endmodule

// ==== prn_scrambler.sv ====
// Scrambling word generator for the return path, restarted by a host command
module prn_scrambler
(
   input  logic       clock,
   input  logic       rst,
   rio_cmd_if.sink    cmd,
   output logic [7:0] prn_word
);

   localparam int lw        = rio_pkg::lfsr_width;
   localparam int div_width = $clog2(rio_pkg::byte_slots);

   logic [lw-1:0]        lfsr;
   logic [div_width-1:0] div_cnt;   // Steps the register once per transmitted byte
   logic                 restart;

   // Eight Fibonacci steps, taps at bits 22 and 21
   function automatic logic [lw-1:0] step8(input logic [lw-1:0] s);
      logic [lw-1:0] r;
      r = s;
      for (int i = 0; i < 8; i++)
      begin
         r = {r[lw-2:0], r[lw-1] ^ r[lw-2]};
      end
      return r;
   endfunction

   assign restart  = cmd.wvalid && (cmd.addr == rio_pkg::addr_prn_reset);
   assign prn_word = lfsr[7:0];

   always_ff @(posedge clock)
   begin
      if (rst || restart)
      begin
         lfsr    <= rio_pkg::lfsr_seed;
         div_cnt <= '0;
      end
      else
      begin
         div_cnt <= div_cnt + 1'b1;
         if (div_cnt == '0)
         begin
            lfsr <= step8(lfsr);
         end
      end
   end

endmodule

// ==== frame_transmitter.sv ====
// Return path serializer, sends scrambled converter bytes, the marker and the readback byte
module frame_transmitter
(
   input  logic       clock,
   input  logic       rst,
   rio_cmd_if.sink    cmd,
   input  logic [7:0] adc_bus,
   input  logic [7:0] prn_word,
   input  logic [7:0] spi0_rdata,
   input  logic [7:0] spi1_rdata,
   output logic [1:0] tx_pair
);

   localparam int sub_bits   = $clog2(rio_pkg::byte_slots);
   localparam int grp_width  = rio_pkg::slot_width - sub_bits;

   logic [grp_width-1:0] grp;         // Byte group of the current slot
   logic                 load;        // First clock of a byte group
   logic [7:0]           adc_q;       // Registered converter bus
   logic [7:0]           tsr;         // Outgoing byte shift register
   logic                 chan_err;    // Training pattern mismatch seen in this frame
   logic [3:0]           train_exp;   // Expected training nibble for this group
   logic [7:0]           rb_next;
   logic [7:0]           rb_byte;     // Readback byte frozen ahead of its group

   assign grp  = cmd.slot[rio_pkg::slot_width-1:sub_bits];
   assign load = (cmd.slot[sub_bits-1:0] == '0);

   always_comb
   begin
      case (grp)
         0:       train_exp = rio_pkg::train_pattern_0;
         1:       train_exp = rio_pkg::train_pattern_1;
         default: train_exp = rio_pkg::train_pattern_2;
      endcase
   end

   always_comb
   begin
      case (cmd.addr)
         rio_pkg::addr_spi0:   rb_next = spi0_rdata;
         rio_pkg::addr_spi1:   rb_next = spi1_rdata;
         rio_pkg::addr_status: rb_next = {7'b0, chan_err};
         default:              rb_next = cmd.wdata[7:0];   // Echo of the write data
      endcase
   end

   always_ff @(posedge clock)
   begin
      adc_q <= adc_bus;
      // Snapshot after the last data byte so the readback stays stable through the marker
      if (load && (grp == rio_pkg::last_data_group))
      begin
         rb_byte <= rb_next;
      end
   end

   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         tsr      <= 8'hFF;
         tx_pair  <= 2'b11;
         chan_err <= 1'b0;
      end
      else
      begin
         if (load)
         begin
            if (grp == rio_pkg::marker_group)
            begin
               tsr <= 8'hFF;
            end
            else if (grp == rio_pkg::readback_group)
            begin
               tsr <= rb_byte;
            end
            else
            begin
               tsr <= adc_q ^ prn_word;
            end
         end
         else
         begin
            tsr <= {tsr[5:0], 2'b11};
         end

         // Group 0 restarts the check, groups 1 and 2 accumulate into it
         if (load && (grp < rio_pkg::first_data_group))
         begin
            chan_err <= ((grp != '0) && chan_err) || (adc_q[3:0] != train_exp);
         end

         tx_pair <= tsr[7:6];   // Byte leaves MSB first
      end
   end

endmodule

// ==== frame_receiver.sv ====
// Host frame receiver, tracks the frame slot and decodes each frame into one command strobe
module frame_receiver
(
   input  logic       clock,
   input  logic       rst,
   input  logic [1:0] rx_pair,
   rio_cmd_if.source  cmd
);

   localparam int word_width = rio_pkg::addr_width + rio_pkg::data_width;

   logic [word_width-1:0] pair_sr;   // Last ten received bit pairs
   logic                  idle_win;  // A new frame may start in this slot

   assign idle_win = (cmd.slot == '0) || (cmd.slot > rio_pkg::idle_check_slot);

   // The shift register runs freely, only the capture slot gives it meaning
   always_ff @(posedge clock)
   begin
      pair_sr <= {pair_sr[word_width-3:0], rx_pair};
   end

   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         cmd.slot   <= '0;
         cmd.wvalid <= 1'b0;
         cmd.addr   <= '0;
         cmd.wdata  <= '0;
      end
      else
      begin
         if (idle_win && !rx_pair[1])
         begin
            cmd.slot <= rio_pkg::slot_width'(1);   // Start pair seen
         end
         else if (cmd.slot == rio_pkg::slot_width'(rio_pkg::frame_len - 1))
         begin
            cmd.slot <= '0;
         end
         else if (cmd.slot != '0)
         begin
            cmd.slot <= cmd.slot + 1'b1;
         end

         // Pairs of slots 1 to 10 sit in the shift register at this edge
         if (cmd.slot == rio_pkg::capture_slot)
         begin
            {cmd.addr, cmd.wdata} <= pair_sr;
         end

         cmd.wvalid <= (cmd.slot == rio_pkg::capture_slot);
      end
   end

endmodule

// ==== rio_cmd_if.sv ====
// Decoded host command and frame slot, driven by the receiver and read by all command consumers
interface rio_cmd_if;

   logic                            wvalid;   // One cycle strobe per decoded command
   logic [rio_pkg::addr_width-1:0]  addr;     // Register address of the last command
   logic [rio_pkg::data_width-1:0]  wdata;    // Write data of the last command
   logic [rio_pkg::slot_width-1:0]  slot;     // Current slot within the frame

   modport source
   (
      output wvalid,
      output addr,
      output wdata,
      output slot
   );

   modport sink
   (
      input wvalid,
      input addr,
      input wdata,
      input slot
   );

endinterface

// ==== rio_pkg.sv ====
// Shared constants of the remote IO target, referenced by scoped name from every block
package rio_pkg;

   // Frame geometry
   localparam int frame_len       = 128;   // Slots per host frame
   localparam int slot_width      = 7;     // Width of the slot counter
   localparam int idle_check_slot = 120;   // A start pair is accepted above this slot
   localparam int capture_slot    = 11;    // Slot where the command word is latched

   // Command word fields
   localparam int addr_width = 4;
   localparam int data_width = 16;

   // Transmit byte grouping
   localparam int byte_slots       = 4;    // Clocks per transmitted byte
   localparam int marker_group     = 27;   // All ones marker byte
   localparam int readback_group   = 28;   // Readback byte
   localparam int first_data_group = 3;    // First scrambled converter byte
   localparam int last_data_group  = 26;   // Last scrambled converter byte

   // Register addresses, anything else echoes the write data
   localparam logic [addr_width-1:0] addr_sync      = 4'd1;
   localparam logic [addr_width-1:0] addr_spi0      = 4'd2;
   localparam logic [addr_width-1:0] addr_spi1      = 4'd3;
   localparam logic [addr_width-1:0] addr_prn_reset = 4'd4;
   localparam logic [addr_width-1:0] addr_status    = 4'd6;

   // Expected low nibble of the converter bus in byte groups 0 to 2
   localparam logic [3:0] train_pattern_0 = 4'b0000;
   localparam logic [3:0] train_pattern_1 = 4'b1100;
   localparam logic [3:0] train_pattern_2 = 4'b1010;

   // Scrambler
   localparam int                    lfsr_width = 22;
   localparam logic [lfsr_width-1:0] lfsr_seed  = '1;   // Value after restart

   // Converter SPI
   localparam int spi_len = 16;   // Bits per write transfer

endpackage
